/* hdl/alu_mem_ctrl.sv */
`default_nettype none

module alu_mem_ctrl (
    input  mips_ctrl_pkg::state_e   state,
    input  mips_ctrl_pkg::instr_e   iclass,
    output mips_ctrl_pkg::alu_mem_t alu_mem
);

    mips_ctrl_pkg::alu_op_e exec_op;
    mips_ctrl_pkg::alu_op_e result_op;

    // ------------------------------------------------------------
    // Execute op, start codes for multiply and divide
    always_comb begin
        case (iclass)
            mips_ctrl_pkg::I_SUBU, mips_ctrl_pkg::I_SLT, mips_ctrl_pkg::I_SLTU,
            mips_ctrl_pkg::I_SLTI, mips_ctrl_pkg::I_SLTIU: exec_op = mips_ctrl_pkg::ALU_SUB;
            mips_ctrl_pkg::I_AND, mips_ctrl_pkg::I_ANDI:   exec_op = mips_ctrl_pkg::ALU_AND;
            mips_ctrl_pkg::I_OR, mips_ctrl_pkg::I_ORI:     exec_op = mips_ctrl_pkg::ALU_OR;
            mips_ctrl_pkg::I_XOR, mips_ctrl_pkg::I_XORI:   exec_op = mips_ctrl_pkg::ALU_XOR;
            mips_ctrl_pkg::I_SLL, mips_ctrl_pkg::I_SLLV:   exec_op = mips_ctrl_pkg::ALU_SLL;
            mips_ctrl_pkg::I_SRL, mips_ctrl_pkg::I_SRLV:   exec_op = mips_ctrl_pkg::ALU_SRL;
            mips_ctrl_pkg::I_SRA, mips_ctrl_pkg::I_SRAV:   exec_op = mips_ctrl_pkg::ALU_SRA;
            mips_ctrl_pkg::I_MULT:  exec_op = mips_ctrl_pkg::ALU_MULT;
            mips_ctrl_pkg::I_MULTU: exec_op = mips_ctrl_pkg::ALU_MULTU;
            mips_ctrl_pkg::I_DIV:   exec_op = mips_ctrl_pkg::ALU_DIV;
            mips_ctrl_pkg::I_DIVU:  exec_op = mips_ctrl_pkg::ALU_DIVU;
            default: begin
                exec_op = mips_ctrl_pkg::is_branch(iclass) ? mips_ctrl_pkg::ALU_SUB
                                                           : mips_ctrl_pkg::ALU_ADD;
            end
        endcase
    end

    always_comb begin
        case (iclass)
            mips_ctrl_pkg::I_MULT:  result_op = mips_ctrl_pkg::ALU_MULT_RES;
            mips_ctrl_pkg::I_MULTU: result_op = mips_ctrl_pkg::ALU_MULTU_RES;
            mips_ctrl_pkg::I_DIV:   result_op = mips_ctrl_pkg::ALU_DIV_RES;
            mips_ctrl_pkg::I_DIVU:  result_op = mips_ctrl_pkg::ALU_DIVU_RES;
            default:                result_op = mips_ctrl_pkg::ALU_ADD;
        endcase
    end

    always_comb begin
        alu_mem = '0;
        case (state)
            mips_ctrl_pkg::S_EXEC: begin
                alu_mem.aluop = exec_op;
            end
            mips_ctrl_pkg::S_MEM: begin
                alu_mem.aluop         = result_op;
                alu_mem.byte_store_en = (iclass == mips_ctrl_pkg::I_SB);
                alu_mem.half_store_en = (iclass == mips_ctrl_pkg::I_SH);
                alu_mem.byte_cnt      = {alu_mem.half_store_en, alu_mem.byte_store_en};
            end
            mips_ctrl_pkg::S_WB: begin
                // Load mask, signed and unsigned byte and half
                case (iclass)
                    mips_ctrl_pkg::I_LH:  alu_mem.mask_cnt = 3'd1;
                    mips_ctrl_pkg::I_LHU: alu_mem.mask_cnt = 3'd2;
                    mips_ctrl_pkg::I_LB:  alu_mem.mask_cnt = 3'd3;
                    mips_ctrl_pkg::I_LBU: alu_mem.mask_cnt = 3'd4;
                    default:              alu_mem.mask_cnt = 3'd0;
                endcase
            end
            default: begin
                alu_mem = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/ctrl_decoder.sv */
`default_nettype none

module ctrl_decoder (
    input  logic                         clk,
    input  logic                         rst_n,
    input  mips_ctrl_pkg::state_e        state,
    input  mips_ctrl_pkg::instr_fields_t instr,
    output mips_ctrl_pkg::path_sel_t     path,
    output mips_ctrl_pkg::strobe_t       strobes,
    output mips_ctrl_pkg::alu_mem_t      alu_mem
);

    mips_ctrl_pkg::instr_e iclass;

    instr_classifier u_classifier (
        .clk    (clk),
        .rst_n  (rst_n),
        .state  (state),
        .instr  (instr),
        .iclass (iclass)
    );

    path_select u_path_select (
        .state  (state),
        .iclass (iclass),
        .path   (path)
    );

    strobe_gen u_strobe_gen (
        .state   (state),
        .iclass  (iclass),
        .strobes (strobes)
    );

    alu_mem_ctrl u_alu_mem_ctrl (
        .state   (state),
        .iclass  (iclass),
        .alu_mem (alu_mem)
    );

endmodule

`default_nettype wire

/* hdl/instr_classifier.sv */
`default_nettype none

`include "mips_ctrl_defs.svh"

module instr_classifier (
    input  logic                         clk,
    input  logic                         rst_n,
    input  mips_ctrl_pkg::state_e        state,
    input  mips_ctrl_pkg::instr_fields_t instr,
    output mips_ctrl_pkg::instr_e        iclass
);

    mips_ctrl_pkg::instr_e decoded;
    mips_ctrl_pkg::instr_e held;

    // ------------------------------------------------------------
    // Field decode
    always_comb begin
        decoded = mips_ctrl_pkg::I_NOP;
        case (instr.opcode)
            `OP_SPECIAL: begin
                case (instr.funct)
                    `FN_SLL:   decoded = mips_ctrl_pkg::I_SLL;
                    `FN_SRL:   decoded = mips_ctrl_pkg::I_SRL;
                    `FN_SRA:   decoded = mips_ctrl_pkg::I_SRA;
                    `FN_SLLV:  decoded = mips_ctrl_pkg::I_SLLV;
                    `FN_SRLV:  decoded = mips_ctrl_pkg::I_SRLV;
                    `FN_SRAV:  decoded = mips_ctrl_pkg::I_SRAV;
                    `FN_JR:    decoded = mips_ctrl_pkg::I_JR;
                    `FN_JALR:  decoded = mips_ctrl_pkg::I_JALR;
                    `FN_MFHI:  decoded = mips_ctrl_pkg::I_MFHI;
                    `FN_MTHI:  decoded = mips_ctrl_pkg::I_MTHI;
                    `FN_MFLO:  decoded = mips_ctrl_pkg::I_MFLO;
                    `FN_MTLO:  decoded = mips_ctrl_pkg::I_MTLO;
                    `FN_MULT:  decoded = mips_ctrl_pkg::I_MULT;
                    `FN_MULTU: decoded = mips_ctrl_pkg::I_MULTU;
                    `FN_DIV:   decoded = mips_ctrl_pkg::I_DIV;
                    `FN_DIVU:  decoded = mips_ctrl_pkg::I_DIVU;
                    `FN_ADDU:  decoded = mips_ctrl_pkg::I_ADDU;
                    `FN_SUBU:  decoded = mips_ctrl_pkg::I_SUBU;
                    `FN_AND:   decoded = mips_ctrl_pkg::I_AND;
                    `FN_OR:    decoded = mips_ctrl_pkg::I_OR;
                    `FN_XOR:   decoded = mips_ctrl_pkg::I_XOR;
                    `FN_SLT:   decoded = mips_ctrl_pkg::I_SLT;
                    `FN_SLTU:  decoded = mips_ctrl_pkg::I_SLTU;
                    default:   decoded = mips_ctrl_pkg::I_NOP;
                endcase
            end
            `OP_REGIMM: begin
                case (instr.rt)
                    `RT_ZERO:   decoded = mips_ctrl_pkg::I_BLTZ;
                    `RT_BGEZ:   decoded = mips_ctrl_pkg::I_BGEZ;
                    `RT_BLTZAL: decoded = mips_ctrl_pkg::I_BLTZAL;
                    `RT_BGEZAL: decoded = mips_ctrl_pkg::I_BGEZAL;
                    default:    decoded = mips_ctrl_pkg::I_NOP;
                endcase
            end
            `OP_BLEZ:  decoded = (instr.rt == `RT_ZERO) ? mips_ctrl_pkg::I_BLEZ
                                                        : mips_ctrl_pkg::I_NOP;
            `OP_BGTZ:  decoded = (instr.rt == `RT_ZERO) ? mips_ctrl_pkg::I_BGTZ
                                                        : mips_ctrl_pkg::I_NOP;
            `OP_BEQ:   decoded = mips_ctrl_pkg::I_BEQ;
            `OP_BNE:   decoded = mips_ctrl_pkg::I_BNE;
            `OP_J:     decoded = mips_ctrl_pkg::I_J;
            `OP_JAL:   decoded = mips_ctrl_pkg::I_JAL;
            `OP_ADDIU: decoded = mips_ctrl_pkg::I_ADDIU;
            `OP_SLTI:  decoded = mips_ctrl_pkg::I_SLTI;
            `OP_SLTIU: decoded = mips_ctrl_pkg::I_SLTIU;
            `OP_ANDI:  decoded = mips_ctrl_pkg::I_ANDI;
            `OP_ORI:   decoded = mips_ctrl_pkg::I_ORI;
            `OP_XORI:  decoded = mips_ctrl_pkg::I_XORI;
            `OP_LUI:   decoded = mips_ctrl_pkg::I_LUI;
            `OP_LB:    decoded = mips_ctrl_pkg::I_LB;
            `OP_LH:    decoded = mips_ctrl_pkg::I_LH;
            `OP_LW:    decoded = mips_ctrl_pkg::I_LW;
            `OP_LBU:   decoded = mips_ctrl_pkg::I_LBU;
            `OP_LHU:   decoded = mips_ctrl_pkg::I_LHU;
            `OP_SB:    decoded = mips_ctrl_pkg::I_SB;
            `OP_SH:    decoded = mips_ctrl_pkg::I_SH;
            `OP_SW:    decoded = mips_ctrl_pkg::I_SW;
            default:   decoded = mips_ctrl_pkg::I_NOP;
        endcase
    end

    // Class held from decode until the next fetch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held <= mips_ctrl_pkg::I_NOP;
        end else if (state == mips_ctrl_pkg::S_DECODE) begin
            held <= decoded;
        end else if (state == mips_ctrl_pkg::S_FETCH) begin
            held <= mips_ctrl_pkg::I_NOP;
        end
    end

    always_comb begin
        case (state)
            mips_ctrl_pkg::S_DECODE: iclass = decoded;
            mips_ctrl_pkg::S_FETCH:  iclass = mips_ctrl_pkg::I_NOP;
            default:                 iclass = held;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/mips_ctrl_pkg.sv */
`default_nettype none

`include "mips_ctrl_defs.svh"

package mips_ctrl_pkg;

    typedef enum logic [`STATE_W-1:0] {
        S_FETCH  = 4'd0,
        S_DECODE = 4'd1,
        S_EXEC   = 4'd2,
        S_MEM    = 4'd3,
        S_WB     = 4'd4
    } state_e;

    typedef enum logic [5:0] {
        I_NOP, I_ADDU, I_ADDIU, I_SUBU, I_AND, I_ANDI, I_OR, I_ORI,
        I_XOR, I_XORI, I_LUI, I_SLT, I_SLTU, I_SLTI, I_SLTIU,
        I_SLL, I_SRL, I_SRA, I_SLLV, I_SRLV, I_SRAV,
        I_MTHI, I_MTLO, I_MFHI, I_MFLO, I_MULT, I_MULTU, I_DIV, I_DIVU,
        I_LW, I_LB, I_LBU, I_LH, I_LHU, I_SW, I_SB, I_SH,
        I_BEQ, I_BNE, I_BGEZ, I_BGTZ, I_BLEZ, I_BLTZ, I_BGEZAL, I_BLTZAL,
        I_J, I_JAL, I_JR, I_JALR
    } instr_e;

    // Odd codes of the multiply/divide group read the result
    typedef enum logic [`ALUOP_W-1:0] {
        ALU_ADD       = 4'd0,
        ALU_SUB       = 4'd1,
        ALU_AND       = 4'd2,
        ALU_OR        = 4'd3,
        ALU_XOR       = 4'd4,
        ALU_SLL       = 4'd5,
        ALU_SRL       = 4'd6,
        ALU_SRA       = 4'd7,
        ALU_MULT      = 4'd8,
        ALU_MULT_RES  = 4'd9,
        ALU_MULTU     = 4'd10,
        ALU_MULTU_RES = 4'd11,
        ALU_DIV       = 4'd12,
        ALU_DIV_RES   = 4'd13,
        ALU_DIVU      = 4'd14,
        ALU_DIVU_RES  = 4'd15
    } alu_op_e;

    typedef struct packed {
        logic [`OPCODE_W-1:0] opcode;
        logic [`FUNCT_W-1:0]  funct;
        logic [`RT_W-1:0]     rt;
    } instr_fields_t;

    typedef struct packed {
        logic [1:0]             mem_to_reg;
        logic [1:0]             reg_dst;
        logic [1:0]             pc_src;
        logic [1:0]             i_or_d;
        logic [1:0]             alu_src_a;
        logic [`ALUSRCB_W-1:0]  alu_src_b;
        logic [1:0]             extend_cont;
        logic                   extend_mux;
        logic                   ab_switch;
    } path_sel_t;

    typedef struct packed {
        logic ir_write;
        logic mem_write;
        logic mem_read;
        logic pc_write;
        logic reg_write;
        logic alt_pc_write;
        logic alt_pc_mux;
        logic hilo_write;
        logic hilo_sel;
        logic link_en;
        logic link_in;
        logic alt_link_reg_en;
        logic alt_link;
    } strobe_t;

    typedef struct packed {
        alu_op_e             aluop;
        logic [`MASK_W-1:0]  mask_cnt;
        logic [1:0]          byte_cnt;
        logic                byte_store_en;
        logic                half_store_en;
    } alu_mem_t;

    // ------------------------------------------------------------
    // Instruction groups shared by the generators
    function automatic logic is_branch(instr_e c);
        return c inside {I_BEQ, I_BNE, I_BGEZ, I_BGTZ, I_BLEZ, I_BLTZ, I_BGEZAL, I_BLTZAL};
    endfunction

    function automatic logic is_link(instr_e c);
        return c inside {I_BGEZAL, I_BLTZAL, I_JAL, I_JALR};
    endfunction

    function automatic logic is_load(instr_e c);
        return c inside {I_LW, I_LB, I_LBU, I_LH, I_LHU};
    endfunction

    function automatic logic is_store(instr_e c);
        return c inside {I_SW, I_SB, I_SH};
    endfunction

    function automatic logic is_muldiv(instr_e c);
        return c inside {I_MULT, I_MULTU, I_DIV, I_DIVU};
    endfunction

    // Classes that take the immediate as ALU operand B
    function automatic logic is_imm(instr_e c);
        return c inside {I_ADDIU, I_ANDI, I_ORI, I_XORI, I_SLTI, I_SLTIU, I_LUI}
            || is_load(c) || is_store(c);
    endfunction

    function automatic logic is_sext(instr_e c);
        return c inside {I_ADDIU, I_SLTI, I_SLTIU}
            || is_load(c) || is_store(c) || is_branch(c);
    endfunction

    function automatic logic is_rtype(instr_e c);
        return c inside {I_ADDU, I_SUBU, I_AND, I_OR, I_XOR, I_SLT, I_SLTU,
                         I_SLL, I_SRL, I_SRA, I_SLLV, I_SRLV, I_SRAV,
                         I_MFHI, I_MFLO, I_JR} || is_muldiv(c);
    endfunction

    // Results written back from the ALU in the memory state
    function automatic logic is_alu_wb(instr_e c);
        return c inside {I_LUI, I_ADDIU, I_ANDI, I_ORI, I_XORI, I_SLTI, I_SLTIU,
                         I_ADDU, I_SUBU, I_AND, I_OR, I_XOR, I_SLT, I_SLTU,
                         I_SLL, I_SRL, I_SRA, I_SLLV, I_SRLV, I_SRAV,
                         I_MFHI, I_MFLO};
    endfunction

endpackage

`default_nettype wire

/* hdl/path_select.sv */
`default_nettype none

module path_select (
    input  mips_ctrl_pkg::state_e    state,
    input  mips_ctrl_pkg::instr_e    iclass,
    output mips_ctrl_pkg::path_sel_t path
);

    logic       link;
    logic       shift_imm;
    logic       shift_var;
    logic       reg_move;
    logic [1:0] ext_sel;

    assign link      = mips_ctrl_pkg::is_link(iclass);
    assign shift_imm = iclass inside {mips_ctrl_pkg::I_SLL, mips_ctrl_pkg::I_SRL,
                                      mips_ctrl_pkg::I_SRA};
    assign shift_var = iclass inside {mips_ctrl_pkg::I_SLLV, mips_ctrl_pkg::I_SRLV,
                                      mips_ctrl_pkg::I_SRAV};
    // hi/lo moves and register jumps pass a register through the ALU
    assign reg_move  = iclass inside {mips_ctrl_pkg::I_MTHI, mips_ctrl_pkg::I_MTLO,
                                      mips_ctrl_pkg::I_MFHI, mips_ctrl_pkg::I_MFLO,
                                      mips_ctrl_pkg::I_JR, mips_ctrl_pkg::I_JALR};

    always_comb begin
        if (mips_ctrl_pkg::is_sext(iclass)) begin
            ext_sel = 2'b10;
        end else if (iclass == mips_ctrl_pkg::I_LUI) begin
            ext_sel = 2'b11;
        end else begin
            ext_sel = 2'b00;
        end
    end

    always_comb begin
        path = '0;
        case (state)
            mips_ctrl_pkg::S_FETCH: begin
                path.alu_src_b   = 3'b001;
                path.extend_cont = 2'b10;
            end
            mips_ctrl_pkg::S_DECODE: begin
                if (mips_ctrl_pkg::is_rtype(iclass)) begin
                    path.reg_dst = 2'b01;
                end else if (link && !mips_ctrl_pkg::is_branch(iclass)) begin
                    path.reg_dst = 2'b10;
                end
                path.pc_src      = 2'b10;
                path.alu_src_b   = 3'b011;
                path.extend_cont = ext_sel;
                path.extend_mux  = 1'b1;
            end
            mips_ctrl_pkg::S_EXEC: begin
                if (mips_ctrl_pkg::is_rtype(iclass) || iclass == mips_ctrl_pkg::I_JALR) begin
                    path.reg_dst = 2'b01;
                end else if (link) begin
                    path.reg_dst = 2'b10;
                end
                path.pc_src = 2'b01;
                if (iclass == mips_ctrl_pkg::I_LUI) begin
                    path.alu_src_a = 2'b10;
                end else if (iclass inside {mips_ctrl_pkg::I_MFHI, mips_ctrl_pkg::I_MFLO}) begin
                    path.alu_src_a = 2'b11;
                end else begin
                    path.alu_src_a = 2'b01;
                end
                if (mips_ctrl_pkg::is_imm(iclass)) begin
                    path.alu_src_b = 3'b010;
                end else if (shift_imm) begin
                    path.alu_src_b = 3'b100;
                end else if (shift_var) begin
                    path.alu_src_b = 3'b101;
                end else if (reg_move) begin
                    path.alu_src_b = 3'b110;
                end
                path.ab_switch   = shift_imm || shift_var;
                path.extend_cont = ext_sel;
                path.extend_mux  = 1'b1;
            end
            mips_ctrl_pkg::S_MEM: begin
                path.mem_to_reg  = (iclass inside {mips_ctrl_pkg::I_SLT, mips_ctrl_pkg::I_SLTU,
                                                   mips_ctrl_pkg::I_SLTI,
                                                   mips_ctrl_pkg::I_SLTIU}) ? 2'b10 : 2'b00;
                path.reg_dst     = mips_ctrl_pkg::is_imm(iclass) ? 2'b00 : 2'b01;
                path.i_or_d      = (iclass inside {mips_ctrl_pkg::I_LW, mips_ctrl_pkg::I_SW})
                                   ? 2'b01 : 2'b10;
                path.pc_src      = 2'b01;
                path.alu_src_a   = 2'b01;
                path.extend_cont = ext_sel;
                path.extend_mux  = 1'b1;
            end
            mips_ctrl_pkg::S_WB: begin
                if (mips_ctrl_pkg::is_muldiv(iclass)) begin
                    path.mem_to_reg = 2'b00;
                end else if (link) begin
                    path.mem_to_reg = 2'b11;
                end else begin
                    path.mem_to_reg = 2'b01;
                end
                path.reg_dst     = link ? 2'b10 : 2'b00;
                path.pc_src      = 2'b10;
                path.alu_src_b   = link ? 3'b001 : 3'b011;
                path.extend_cont = ext_sel;
                path.extend_mux  = 1'b1;
            end
            default: begin
                path = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/strobe_gen.sv */
`default_nettype none

module strobe_gen (
    input  mips_ctrl_pkg::state_e  state,
    input  mips_ctrl_pkg::instr_e  iclass,
    output mips_ctrl_pkg::strobe_t strobes
);

    logic store;
    logic mfhi;

    assign store = mips_ctrl_pkg::is_store(iclass);
    assign mfhi  = (iclass == mips_ctrl_pkg::I_MFHI);

    always_comb begin
        strobes = '0;
        case (state)
            mips_ctrl_pkg::S_FETCH: begin
                strobes.ir_write = 1'b1;
                strobes.mem_read = 1'b1;
                strobes.pc_write = 1'b1;
            end
            mips_ctrl_pkg::S_DECODE: begin
                strobes.mem_read     = 1'b1;
                strobes.alt_pc_write = iclass inside {mips_ctrl_pkg::I_J, mips_ctrl_pkg::I_JAL};
                strobes.alt_pc_mux   = 1'b1;
                strobes.hilo_sel     = mfhi;
            end
            mips_ctrl_pkg::S_EXEC: begin
                strobes.mem_read     = 1'b1;
                strobes.alt_pc_write = mips_ctrl_pkg::is_branch(iclass);
                strobes.hilo_sel     = mfhi;
                strobes.link_en      = 1'b1;
                strobes.link_in      = mips_ctrl_pkg::is_link(iclass);
            end
            mips_ctrl_pkg::S_MEM: begin
                strobes.mem_write       = store;
                strobes.mem_read        = !store;
                strobes.reg_write       = mips_ctrl_pkg::is_alu_wb(iclass);
                strobes.alt_pc_write    = iclass inside {mips_ctrl_pkg::I_JR,
                                                         mips_ctrl_pkg::I_JALR};
                strobes.hilo_write      = mips_ctrl_pkg::is_muldiv(iclass)
                                          || iclass inside {mips_ctrl_pkg::I_MTHI,
                                                            mips_ctrl_pkg::I_MTLO};
                strobes.hilo_sel        = mfhi || iclass == mips_ctrl_pkg::I_MTHI;
                strobes.alt_link_reg_en = 1'b1;
                strobes.alt_link        = (iclass == mips_ctrl_pkg::I_JALR);
            end
            mips_ctrl_pkg::S_WB: begin
                // Second hi/lo write takes the other half of the result
                strobes.mem_read   = 1'b1;
                strobes.reg_write  = mips_ctrl_pkg::is_load(iclass)
                                     || mips_ctrl_pkg::is_link(iclass);
                strobes.alt_pc_mux = 1'b1;
                strobes.hilo_write = mips_ctrl_pkg::is_muldiv(iclass);
                strobes.hilo_sel   = mips_ctrl_pkg::is_muldiv(iclass) || mfhi;
            end
            default: begin
                strobes = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* include/mips_ctrl_defs.svh */
`ifndef MIPS_CTRL_DEFS_SVH
`define MIPS_CTRL_DEFS_SVH

// Instruction field widths
`define OPCODE_W  6
`define FUNCT_W   6
`define RT_W      5

// Control widths
`define STATE_W   4
`define ALUOP_W   4
`define ALUSRCB_W 3
`define MASK_W    3

// ------------------------------------------------------------
// Primary opcodes
`define OP_SPECIAL 6'b000000
`define OP_REGIMM  6'b000001
`define OP_J       6'b000010
`define OP_JAL     6'b000011
`define OP_BEQ     6'b000100
`define OP_BNE     6'b000101
`define OP_BLEZ    6'b000110
`define OP_BGTZ    6'b000111
`define OP_ADDIU   6'b001001
`define OP_SLTI    6'b001010
`define OP_SLTIU   6'b001011
`define OP_ANDI    6'b001100
`define OP_ORI     6'b001101
`define OP_XORI    6'b001110
`define OP_LUI     6'b001111
`define OP_LB      6'b100000
`define OP_LH      6'b100001
`define OP_LW      6'b100011
`define OP_LBU     6'b100100
`define OP_LHU     6'b100101
`define OP_SB      6'b101000
`define OP_SH      6'b101001
`define OP_SW      6'b101011

// ------------------------------------------------------------
// SPECIAL function codes
`define FN_SLL   6'b000000
`define FN_SRL   6'b000010
`define FN_SRA   6'b000011
`define FN_SLLV  6'b000100
`define FN_SRLV  6'b000110
`define FN_SRAV  6'b000111
`define FN_JR    6'b001000
`define FN_JALR  6'b001001
`define FN_MFHI  6'b010000
`define FN_MTHI  6'b010001
`define FN_MFLO  6'b010010
`define FN_MTLO  6'b010011
`define FN_MULT  6'b011000
`define FN_MULTU 6'b011001
`define FN_DIV   6'b011010
`define FN_DIVU  6'b011011
`define FN_ADDU  6'b100001
`define FN_SUBU  6'b100011
`define FN_AND   6'b100100
`define FN_OR    6'b100101
`define FN_XOR   6'b100110
`define FN_SLT   6'b101010
`define FN_SLTU  6'b101011

// REGIMM rt codes, rt must be zero for blez/bgtz
`define RT_ZERO   5'b00000
`define RT_BGEZ   5'b00001
`define RT_BLTZAL 5'b10000
`define RT_BGEZAL 5'b10001

`endif

/* run_sim.sh */
#!/bin/sh
# Build the control decoder testbench with Verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module ctrl_decoder_tb \
    -o ctrl_decoder_sim > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/ctrl_decoder_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0

/* tb/ctrl_decoder_tb.sv */
`default_nettype none

module ctrl_decoder_tb;

    localparam int CLK_PERIOD = 100;

    typedef struct packed {
        mips_ctrl_pkg::state_e        state;
        mips_ctrl_pkg::instr_fields_t instr;
        mips_ctrl_pkg::path_sel_t     path;
        mips_ctrl_pkg::strobe_t       strobes;
        mips_ctrl_pkg::alu_mem_t      alu_mem;
    } pattern_t;

    logic                         clk;
    logic                         rst_n;
    mips_ctrl_pkg::state_e        state;
    mips_ctrl_pkg::instr_fields_t instr;
    mips_ctrl_pkg::path_sel_t     path;
    mips_ctrl_pkg::strobe_t       strobes;
    mips_ctrl_pkg::alu_mem_t      alu_mem;

    pattern_t patterns[$];
    logic     loaded;

    ctrl_decoder UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .state   (state),
        .instr   (instr),
        .path    (path),
        .strobes (strobes),
        .alu_mem (alu_mem)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------
    task automatic report_mismatch(input string name, input int row,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("Fail at time %0t: row %0d %s expected %h, got %h",
                 $time, row, name, expected, actual);
        $display("Simulation failed");
        $fatal(1, "output mismatch");
    endtask

    task automatic load_patterns;
        int         fd;
        int         fields;
        string      line;
        pattern_t   row;
        logic [3:0] st;
        logic [5:0] op;
        logic [5:0] fn;
        logic [4:0] rt;
        logic [16:0] p;
        logic [12:0] s;
        logic [10:0] a;
        fd = $fopen("tb/ctrl_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file tb/ctrl_patterns.txt");
            $display("Simulation failed");
            $fatal(1, "missing pattern file");
        end
        while ($fgets(line, fd) != 0) begin
            // Skip blank and comment lines
            if (line.len() == 0 || line[0] == "\n" || line[0] == "#") begin
                continue;
            end
            fields = $sscanf(line, "%h %h %h %h %h %h %h", st, op, fn, rt, p, s, a);
            if (fields != 7) begin
                $display("Malformed pattern row: %s", line);
                $display("Simulation failed");
                $fatal(1, "bad pattern row");
            end
            row.state   = mips_ctrl_pkg::state_e'(st);
            row.instr   = {op, fn, rt};
            row.path    = p;
            row.strobes = s;
            row.alu_mem = a;
            patterns.push_back(row);
        end
        $fclose(fd);
    endtask

    task automatic check_outputs(input pattern_t pat, input int row);
        assert (path === pat.path)
            else report_mismatch("path", row, 32'(pat.path), 32'(path));
        assert (strobes === pat.strobes)
            else report_mismatch("strobes", row, 32'(pat.strobes), 32'(strobes));
        assert (alu_mem === pat.alu_mem)
            else report_mismatch("alu_mem", row, 32'(pat.alu_mem), 32'(alu_mem));
    endtask

    // ------------------------------------------------------------
    // Main sequence
    initial begin
        rst_n  = 1'b0;
        state  = mips_ctrl_pkg::S_FETCH;
        instr  = '0;
        loaded = 1'b0;
        load_patterns();
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        foreach (patterns[i]) begin
            @(negedge clk);
            state = patterns[i].state;
            instr = patterns[i].instr;
            // Sample the combinational outputs well before the next edge
            #(CLK_PERIOD / 4);
            check_outputs(patterns[i], i);
        end
        if (patterns.size() > 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("No pattern rows were checked");
            $display("Simulation failed");
            $fatal(1, "empty pattern set");
        end
    end

    // Watchdog sized from the pattern count
    initial begin
        wait (loaded);
        #((patterns.size() + 10) * CLK_PERIOD);
        $display("Watchdog timeout, the pattern run did not finish in time");
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

/* tb/ctrl_patterns.txt */
# state opcode funct rt | expected path strobes alu_mem, all hex
# Rows run in order, the class is held from each decode row
3 00 00 00 02c82 0402 000
4 00 00 00 09032 0440 000
0 00 21 00 00018 1600 000
1 00 21 00 03032 0440 000
2 00 21 00 02882 0408 000
3 00 21 00 02c82 0502 000
0 0a 00 00 00018 1600 000
1 0a 00 00 0103a 0440 000
2 0a 00 00 008aa 0408 080
3 0a 00 00 10c8a 0502 000
1 00 07 00 03032 0440 000
2 00 07 00 028d3 0408 380
0 20 00 00 00018 1600 000
1 20 00 00 0103a 0440 000
2 20 00 00 008aa 0408 000
3 20 00 00 00c8a 0402 000
4 20 00 00 0903a 0540 030
1 25 00 00 0103a 0440 000
4 25 00 00 0903a 0540 020
1 23 00 00 0103a 0440 000
3 23 00 00 00a8a 0402 000
1 28 00 00 0103a 0440 000
3 28 00 00 00c8a 0802 006
1 29 00 00 0103a 0440 000
3 29 00 00 00c8a 0802 009
1 04 00 00 0103a 0440 000
2 04 00 00 0088a 0488 080
1 01 00 11 0103a 0440 000
2 01 00 11 0488a 048c 080
4 01 00 11 1d01a 0540 000
1 03 00 00 05032 04c0 000
1 00 09 00 05032 0440 000
2 00 09 00 028e2 040c 000
3 00 09 00 02c82 0483 000
1 00 18 00 03032 0440 000
2 00 18 00 02882 0408 400
3 00 18 00 02c82 0422 480
4 00 18 00 01032 0470 000
1 00 1b 00 03032 0440 000
2 00 1b 00 02882 0408 700
3 00 1b 00 02c82 0422 780
1 00 11 00 01032 0440 000
3 00 11 00 02c82 0432 000
1 00 10 00 03032 0450 000
2 00 10 00 029e2 0418 000
1 3f 00 00 01032 0440 000
2 3f 00 00 00882 0408 000
3 3f 00 00 02c82 0402 000
0 3f 00 00 00018 1600 000

/* vlog.f */
+incdir+include
hdl/mips_ctrl_pkg.sv
hdl/instr_classifier.sv
hdl/path_select.sv
hdl/strobe_gen.sv
hdl/alu_mem_ctrl.sv
hdl/ctrl_decoder.sv
tb/ctrl_decoder_tb.sv
